// ==== hw/fetch_pkg.sv ====
/*
 * fetch stage shared definitions
 * sizes, fetch states and the packed structs carried between the
 * scheduler, the instruction cache and the instruction buffer
 */
package fetch_pkg;

    localparam int NUM_WARPS         = 4;
    localparam int NUM_THREADS       = 4;
    localparam int NW_WIDTH          = 2;
    localparam int UUID_WIDTH        = 8;
    localparam int IBUF_SIZE         = 4;
    localparam int ICACHE_ADDR_WIDTH = 30;

    // counter must reach IBUF_SIZE itself
    localparam int IBUF_CNT_WIDTH    = $clog2(IBUF_SIZE + 1);

    typedef enum logic [1:0] {
        ST_LOW   = 2'b00,
        ST_HIGH  = 2'b01,
        ST_SPLIT = 2'b10
    } fetch_state_t;

    typedef struct packed {
        logic [NW_WIDTH-1:0]    wid;
        logic [31:0]            pc;
        logic [NUM_THREADS-1:0] tmask;
        fetch_state_t           state;
        logic [UUID_WIDTH-1:0]  uuid;
    } schedule_t;

    typedef struct packed {
        logic [UUID_WIDTH-1:0] uuid;
        logic [NW_WIDTH-1:0]   wid;
    } icache_tag_t;

    typedef struct packed {
        logic [ICACHE_ADDR_WIDTH-1:0] addr;
        icache_tag_t                  tag;
    } icache_req_t;

    typedef struct packed {
        logic [31:0] data;
        icache_tag_t tag;
    } icache_rsp_t;

    // context of the request in flight for one warp
    typedef struct packed {
        logic [31:0]            pc;
        logic [NUM_THREADS-1:0] tmask;
        fetch_state_t           state;
    } tag_entry_t;

    typedef struct packed {
        logic [NW_WIDTH-1:0]    wid;
        logic [31:0]            pc;
        logic [NUM_THREADS-1:0] tmask;
        logic [UUID_WIDTH-1:0]  uuid;
        logic [31:0]            instr;
        logic                   rvc;
        fetch_state_t           next_state;
        logic                   incomplete;
    } fetch_t;

endpackage

// ==== hw/fetch_elastic_buf.sv ====
/*
 * two-entry elastic buffer
 * registered output plus a spill slot, so ready is also a register
 */
`timescale 1ns/1ps

module fetch_elastic_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     spill_valid;
    payload_t spill_data;
    logic     out_free;

    // output slot can take a new entry this cycle
    assign out_free = out_ready || !out_valid;
    assign in_ready = !spill_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            spill_valid <= 1'b0;
        end else if (out_free) begin
            out_valid   <= spill_valid || in_valid;
            spill_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            spill_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            // spill entry is older, drain it first
            out_data <= spill_valid ? spill_data : in_data;
        end else if (in_valid && in_ready) begin
            spill_data <= in_data;
        end
    end

endmodule

// ==== hw/fetch_pending_count.sv ====
/*
 * pending instruction counter for one warp
 * counts fetches not yet popped from the instruction buffer
 */
`timescale 1ns/1ps

module fetch_pending_count (
    input  logic clk,
    input  logic rst_n,
    input  logic incr,
    input  logic decr,
    output logic full
);
    import fetch_pkg::*;

    logic [IBUF_CNT_WIDTH-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (incr && !decr) begin
            count <= count + 1'b1;
        end else if (decr && !incr && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign full = (count == IBUF_CNT_WIDTH'(IBUF_SIZE));

endmodule

// ==== hw/fetch_tag_store.sv ====
/*
 * warp-indexed tag store
 * keeps pc, tmask and state of each warp's fetch in flight
 */
`timescale 1ns/1ps

module fetch_tag_store (
    input  logic                         clk,
    input  logic [fetch_pkg::NW_WIDTH-1:0] waddr,
    input  logic                         wen,
    input  fetch_pkg::tag_entry_t        wdata,
    input  logic [fetch_pkg::NW_WIDTH-1:0] raddr,
    output fetch_pkg::tag_entry_t        rdata
);
    import fetch_pkg::*;

    tag_entry_t mem [NUM_WARPS];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // lut read, response looks up its context in the same cycle
    assign rdata = mem[raddr];

endmodule

// ==== hw/fetch_decompress.sv ====
/*
 * compressed instruction expander
 * picks the instruction out of a cache word, expands rvc halves,
 * joins instructions split across words and registers the result
 */
`timescale 1ns/1ps

module fetch_decompress (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [31:0]                      in_pc,
    input  logic [fetch_pkg::NUM_THREADS-1:0] in_tmask,
    input  logic [fetch_pkg::NW_WIDTH-1:0]   in_wid,
    input  logic [fetch_pkg::UUID_WIDTH-1:0] in_uuid,
    input  fetch_pkg::fetch_state_t          in_state,
    input  logic [31:0]                      in_word,
    output logic                             out_valid,
    input  logic                             out_ready,
    output fetch_pkg::fetch_t                out_data
);
    import fetch_pkg::*;

    logic [15:0] saved_half [NUM_WARPS];
    logic [15:0] lo_half;
    logic [15:0] hi_half;
    logic        save_hi;
    fetch_t      result;

    // c.addi, c.li, c.mv and c.add only
    function automatic logic [31:0] expand(input logic [15:0] c);
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        imm    = {{6{c[12]}}, c[12], c[6:2]};
        rd     = c[11:7];
        rs2    = c[6:2];
        expand = '0;
        if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
            expand = {imm, rd, 3'b000, rd, 7'b0010011};
        end else if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
            expand = {imm, 5'd0, 3'b000, rd, 7'b0010011};
        end else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && rs2 != 5'd0) begin
            // bit 12 selects c.add over c.mv
            if (c[12]) begin
                expand = {7'd0, rs2, rd, 3'b000, rd, 7'b0110011};
            end else begin
                expand = {7'd0, rs2, 5'd0, 3'b000, rd, 7'b0110011};
            end
        end
    endfunction

    assign lo_half = in_word[15:0];
    assign hi_half = in_word[31:16];

    always_comb begin
        result            = '0;
        result.wid        = in_wid;
        result.pc         = in_pc;
        result.tmask      = in_tmask;
        result.uuid       = in_uuid;
        result.next_state = ST_LOW;
        unique case (in_state)
            ST_LOW: begin
                if (lo_half[1:0] != 2'b11) begin
                    result.instr      = expand(lo_half);
                    result.rvc        = 1'b1;
                    result.next_state = ST_HIGH;
                end else begin
                    result.instr = in_word;
                end
            end
            ST_HIGH: begin
                if (hi_half[1:0] != 2'b11) begin
                    result.instr = expand(hi_half);
                    result.rvc   = 1'b1;
                end else begin
                    // low half of a 32-bit op, rest is in the next word
                    result.incomplete = 1'b1;
                    result.next_state = ST_SPLIT;
                end
            end
            ST_SPLIT: begin
                result.instr = {lo_half, saved_half[in_wid]};
            end
            default: begin
                result.instr = '0;
            end
        endcase
    end

    assign save_hi = in_valid && in_ready && in_state == ST_HIGH && hi_half[1:0] == 2'b11;

    always_ff @(posedge clk) begin
        if (save_hi) begin
            saved_half[in_wid] <= hi_half;
        end
    end

    fetch_elastic_buf #(
        .payload_t (fetch_t)
    ) out_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (result),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

// ==== hw/fetch_unit.sv ====
/*
 * instruction fetch stage
 * throttles warps on instruction buffer space, issues icache requests
 * and turns icache responses into decoded fetch entries
 */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sched_valid,
    output logic                             sched_ready,
    input  fetch_pkg::schedule_t             sched_data,
    output logic                             icache_req_valid,
    input  logic                             icache_req_ready,
    output fetch_pkg::icache_req_t           icache_req_data,
    input  logic                             icache_rsp_valid,
    output logic                             icache_rsp_ready,
    input  fetch_pkg::icache_rsp_t           icache_rsp_data,
    output logic                             fetch_valid,
    input  logic                             fetch_ready,
    output fetch_pkg::fetch_t                fetch_data,
    input  logic [fetch_pkg::NUM_WARPS-1:0]  ibuf_pop
);
    import fetch_pkg::*;

    logic                 sched_fire;
    logic                 ibuf_ready;
    logic                 req_buf_ready;
    logic [NUM_WARPS-1:0] pending_full;
    icache_req_t          req;
    tag_entry_t           rsp_ctx;

    assign sched_fire  = sched_valid && sched_ready;
    assign ibuf_ready  = !pending_full[sched_data.wid];
    assign sched_ready = req_buf_ready && ibuf_ready;

    // keeps the instruction buffer from overflowing
    for (genvar i = 0; i < NUM_WARPS; i++) begin : g_pending
        fetch_pending_count pending (
            .clk   (clk),
            .rst_n (rst_n),
            .incr  (sched_fire && sched_data.wid == NW_WIDTH'(i)),
            .decr  (ibuf_pop[i]),
            .full  (pending_full[i])
        );
    end

    // split fetch continues in the next word
    assign req.addr = sched_data.pc[2 +: ICACHE_ADDR_WIDTH]
                    + ICACHE_ADDR_WIDTH'(sched_data.state == ST_SPLIT);
    assign req.tag  = '{uuid: sched_data.uuid, wid: sched_data.wid};

    fetch_tag_store tag_store (
        .clk   (clk),
        .waddr (sched_data.wid),
        .wen   (sched_fire),
        .wdata ('{pc: sched_data.pc, tmask: sched_data.tmask, state: sched_data.state}),
        .raddr (icache_rsp_data.tag.wid),
        .rdata (rsp_ctx)
    );

    fetch_elastic_buf #(
        .payload_t (icache_req_t)
    ) req_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sched_valid && ibuf_ready),
        .in_ready  (req_buf_ready),
        .in_data   (req),
        .out_valid (icache_req_valid),
        .out_ready (icache_req_ready),
        .out_data  (icache_req_data)
    );

    fetch_decompress decomp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (icache_rsp_valid),
        .in_ready  (icache_rsp_ready),
        .in_pc     (rsp_ctx.pc),
        .in_tmask  (rsp_ctx.tmask),
        .in_wid    (icache_rsp_data.tag.wid),
        .in_uuid   (icache_rsp_data.tag.uuid),
        .in_state  (rsp_ctx.state),
        .in_word   (icache_rsp_data.data),
        .out_valid (fetch_valid),
        .out_ready (fetch_ready),
        .out_data  (fetch_data)
    );

endmodule

// ==== test/fetch_ref.svh ====
/*
 * fetch reference model
 * random source, rvc expansion and expected fetch results
 */
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// random halfword, biased toward the four supported rvc ops
function automatic logic [15:0] make_half(input logic [31:0] r);
    logic [15:0] h;
    h = r[28:13];
    case (r[31:29])
        3'd0, 3'd1: h[1:0] = 2'b11;
        3'd2: h = {3'b000, h[12:2], 2'b01};
        3'd3: h = {3'b010, h[12:2], 2'b01};
        3'd4: h = {3'b100, h[12:2], 2'b10};
        default: ;
    endcase
    return h;
endfunction

function automatic logic [31:0] ref_expand(input logic [15:0] h);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm;
    rd  = h[11:7];
    rs2 = h[6:2];
    imm = {{7{h[12]}}, h[6:2]};
    case ({h[15:13], h[1:0]})
        5'b000_01: return {imm, rd, 3'b000, rd, 7'h13};
        5'b010_01: return {imm, 5'd0, 3'b000, rd, 7'h13};
        5'b100_10: begin
            // rs2 of zero is c.jr, c.jalr or c.ebreak
            if (rs2 == 5'd0) begin
                return 32'd0;
            end
            return {7'd0, rs2, (h[12] ? rd : 5'd0), 3'b000, rd, 7'h33};
        end
        default: return 32'd0;
    endcase
endfunction

// cur is the requested word, prev the word before it
function automatic fetch_t ref_fetch(input logic [31:0] pc, input fetch_state_t st,
                                     input logic [31:0] cur, input logic [31:0] prev);
    fetch_t      f;
    logic [15:0] half;
    f            = '0;
    f.pc         = pc;
    f.next_state = ST_LOW;
    half         = (st == ST_HIGH) ? cur[31:16] : cur[15:0];
    if (st == ST_SPLIT) begin
        f.instr = {cur[15:0], prev[31:16]};
    end else if (half[1:0] != 2'b11) begin
        f.instr      = ref_expand(half);
        f.rvc        = 1'b1;
        f.next_state = (st == ST_LOW) ? ST_HIGH : ST_LOW;
    end else if (st == ST_LOW) begin
        f.instr = cur;
    end else begin
        f.incomplete = 1'b1;
        f.next_state = ST_SPLIT;
    end
    return f;
endfunction

`endif

// ==== test/tb_fetch.sv ====
/*
 * fetch stage testbench
 * models scheduler, icache and instruction buffer around the DUT
 * and checks every fetch result against the reference model
 */
`timescale 1ns/1ps

module tb_fetch;
    import fetch_pkg::*;

    localparam int          CLK_NS      = 4;
    localparam int          PER_WARP    = 100;
    localparam int          TOTAL       = PER_WARP * NUM_WARPS;
    localparam int          MEM_WORDS   = 1024;
    localparam int          WATCHDOG_NS = TOTAL * 20 * CLK_NS;
    localparam logic [31:0] SEED        = 32'd39610;

    logic                 clk              = 1'b0;
    logic                 rst_n            = 1'b0;
    logic                 sched_valid      = 1'b0;
    logic                 sched_ready;
    schedule_t            sched_data       = '0;
    logic                 icache_req_valid;
    logic                 icache_req_ready = 1'b0;
    icache_req_t          icache_req_data;
    logic                 icache_rsp_valid = 1'b0;
    logic                 icache_rsp_ready;
    icache_rsp_t          icache_rsp_data  = '0;
    logic                 fetch_valid;
    logic                 fetch_ready      = 1'b0;
    fetch_t               fetch_data;
    logic [NUM_WARPS-1:0] ibuf_pop         = '0;

    logic [31:0]            imem [MEM_WORDS];
    logic [31:0]            rng;
    // context of each warp's fetch in flight
    logic [31:0]            ctx_pc    [NUM_WARPS];
    fetch_state_t           ctx_st    [NUM_WARPS];
    logic [NUM_THREADS-1:0] ctx_tmask [NUM_WARPS];
    logic [UUID_WIDTH-1:0]  ctx_uuid  [NUM_WARPS];
    // warp that each issued uuid belongs to
    logic [NW_WIDTH-1:0]    uuid_wid  [1 << UUID_WIDTH];
    logic [31:0]            next_pc   [NUM_WARPS];
    fetch_state_t           next_st   [NUM_WARPS];
    int                     issued    [NUM_WARPS];
    int                     retired   [NUM_WARPS];
    int                     popped    [NUM_WARPS];
    // icache model, one slot per warp
    logic                   slot_busy [NUM_WARPS];
    int                     slot_wait [NUM_WARPS];
    logic [ICACHE_ADDR_WIDTH-1:0] slot_addr [NUM_WARPS];
    icache_tag_t            slot_tag  [NUM_WARPS];
    int                     rsp_wid;
    int                     cur;
    int                     cyc;
    int                     done_total;
    int                     stall_seen;
    logic [UUID_WIDTH-1:0]  uuid_next;

    `include "fetch_ref.svh"

    task automatic report_error(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] want, input logic [31:0] got);
        assert (want == got) else
            report_error($sformatf("[FAIL] %s exp %h got %h", name, want, got));
    endtask

    fetch_unit dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .sched_valid      (sched_valid),
        .sched_ready      (sched_ready),
        .sched_data       (sched_data),
        .icache_req_valid (icache_req_valid),
        .icache_req_ready (icache_req_ready),
        .icache_req_data  (icache_req_data),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_ready (icache_rsp_ready),
        .icache_rsp_data  (icache_rsp_data),
        .fetch_valid      (fetch_valid),
        .fetch_ready      (fetch_ready),
        .fetch_data       (fetch_data),
        .ibuf_pop         (ibuf_pop)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // scheduler, icache, downstream ready and ibuf pops
    always @(posedge clk) begin
        logic [31:0]                  r1;
        logic [31:0]                  r2;
        logic [15:0]                  lo;
        logic [ICACHE_ADDR_WIDTH-1:0] want_addr;
        logic [NUM_WARPS-1:0]         pop_next;
        logic                         fire;
        int                           w;
        int                           pick;
        int                           avail;
        if (!rst_n) begin
            rng = SEED;
            for (int i = 0; i < MEM_WORDS; i++) begin
                rng     = lcg_next(rng);
                lo      = make_half(rng);
                rng     = lcg_next(rng);
                imem[i] = {make_half(rng), lo};
            end
            for (int i = 0; i < NUM_WARPS; i++) begin
                issued[i]    <= 0;
                popped[i]    <= 0;
                slot_busy[i] = 1'b0;
                slot_wait[i] = 0;
            end
            cur              = 0;
            cyc              = 0;
            rsp_wid          = 0;
            uuid_next        = '0;
            stall_seen       <= 0;
            sched_valid      <= 1'b0;
            icache_rsp_valid <= 1'b0;
            icache_req_ready <= 1'b0;
            fetch_ready      <= 1'b0;
            ibuf_pop         <= '0;
        end else begin
            r1  = lcg_next(rng);
            r2  = lcg_next(r1);
            rng = r2;
            cyc = cyc + 1;

            fire = sched_valid && sched_ready;
            if (fire) begin
                w = int'(sched_data.wid);
                assert (issued[w] - popped[w] < IBUF_SIZE) else
                    report_error($sformatf("warp %0d accepted with %0d entries not popped",
                                           w, issued[w] - popped[w]));
                ctx_pc[w]    <= sched_data.pc;
                ctx_st[w]    <= sched_data.state;
                ctx_tmask[w] <= sched_data.tmask;
                ctx_uuid[w]  <= sched_data.uuid;
                uuid_wid[sched_data.uuid] <= sched_data.wid;
                issued[w]    <= issued[w] + 1;
            end else if (sched_valid && issued[cur] - popped[cur] >= IBUF_SIZE) begin
                stall_seen <= stall_seen + 1;
            end
            if (!sched_valid || fire) begin
                pick = -1;
                for (int k = 0; k < NUM_WARPS; k++) begin
                    w = (int'(r1[31:30]) + k) % NUM_WARPS;
                    if (pick < 0 && !(fire && w == cur) && issued[w] == retired[w]
                            && issued[w] < PER_WARP) begin
                        pick = w;
                    end
                end
                if (pick >= 0) begin
                    sched_valid <= 1'b1;
                    sched_data  <= '{wid: NW_WIDTH'(pick), pc: next_pc[pick], tmask: r1[29:26],
                                     state: next_st[pick], uuid: uuid_next};
                    cur         = pick;
                    uuid_next   = uuid_next + 1'b1;
                end else begin
                    sched_valid <= 1'b0;
                end
            end

            // icache responses in any order once their latency ran out
            if (icache_rsp_valid && icache_rsp_ready) begin
                slot_busy[rsp_wid] = 1'b0;
            end
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (slot_wait[i] > 0) begin
                    slot_wait[i] = slot_wait[i] - 1;
                end
            end
            if (!icache_rsp_valid || icache_rsp_ready) begin
                pick = -1;
                for (int k = 0; k < NUM_WARPS; k++) begin
                    w = (int'(r1[21:20]) + k) % NUM_WARPS;
                    if (pick < 0 && slot_busy[w] && slot_wait[w] == 0) begin
                        pick = w;
                    end
                end
                if (pick >= 0) begin
                    icache_rsp_valid <= 1'b1;
                    icache_rsp_data  <= '{data: imem[slot_addr[pick][9:0]], tag: slot_tag[pick]};
                    rsp_wid          = pick;
                end else begin
                    icache_rsp_valid <= 1'b0;
                end
            end
            if (icache_req_valid && icache_req_ready) begin
                w         = int'(uuid_wid[icache_req_data.tag.uuid]);
                want_addr = ctx_pc[w][31:2] + ICACHE_ADDR_WIDTH'(ctx_st[w] == ST_SPLIT);
                check_value("icache_req_data.tag.wid", 32'(w), 32'(icache_req_data.tag.wid));
                check_value("icache_req_data.addr", 32'(want_addr), 32'(icache_req_data.addr));
                check_value("icache_req_data.tag.uuid", 32'(ctx_uuid[w]),
                            32'(icache_req_data.tag.uuid));
                assert (!slot_busy[w]) else
                    report_error($sformatf("second icache request for warp %0d", w));
                slot_busy[w] = 1'b1;
                slot_addr[w] = icache_req_data.addr;
                slot_tag[w]  = icache_req_data.tag;
                slot_wait[w] = 1 + int'(r1[25:22]) % 6;
            end

            fetch_ready      <= r1[19:18] != 2'b00;
            icache_req_ready <= r1[17:16] != 2'b00;
            // pops held off for a quarter of every 256 cycles
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (ibuf_pop[i]) begin
                    popped[i] <= popped[i] + 1;
                end
                avail       = retired[i] - popped[i] - int'(ibuf_pop[i]);
                pop_next[i] = cyc[7:6] != 2'b11 && avail > 0 && r2[28 + i];
            end
            ibuf_pop <= pop_next;
        end
    end

    // compare each accepted fetch result with the reference
    always @(posedge clk) begin
        fetch_t     want;
        logic [9:0] idx;
        int         w;
        if (!rst_n) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                next_pc[i] <= 32'(i * 1024);
                next_st[i] <= ST_LOW;
                retired[i] <= 0;
            end
            done_total <= 0;
        end else if (fetch_valid && fetch_ready) begin
            w = int'(uuid_wid[fetch_data.uuid]);
            assert (issued[w] != retired[w]) else
                report_error($sformatf("result for warp %0d with no fetch in flight", w));
            idx        = ctx_pc[w][11:2];
            want       = ref_fetch(ctx_pc[w], ctx_st[w],
                                   imem[idx + 10'(ctx_st[w] == ST_SPLIT)], imem[idx]);
            want.wid   = NW_WIDTH'(w);
            want.tmask = ctx_tmask[w];
            want.uuid  = ctx_uuid[w];
            check_value("fetch_data.wid", 32'(want.wid), 32'(fetch_data.wid));
            check_value("fetch_data.pc", want.pc, fetch_data.pc);
            check_value("fetch_data.tmask", 32'(want.tmask), 32'(fetch_data.tmask));
            check_value("fetch_data.uuid", 32'(want.uuid), 32'(fetch_data.uuid));
            check_value("fetch_data.instr", want.instr, fetch_data.instr);
            check_value("fetch_data.rvc", 32'(want.rvc), 32'(fetch_data.rvc));
            check_value("fetch_data.next_state", 32'(want.next_state),
                        32'(fetch_data.next_state));
            check_value("fetch_data.incomplete", 32'(want.incomplete),
                        32'(fetch_data.incomplete));
            // split halves are fetched again from the same pc
            next_pc[w] <= want.incomplete ? ctx_pc[w]
                                          : ctx_pc[w] + (want.rvc ? 32'd2 : 32'd4);
            next_st[w] <= want.next_state;
            retired[w] <= retired[w] + 1;
            done_total <= done_total + 1;
        end
    end

    initial begin
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (done_total == TOTAL);
        repeat (20) @(posedge clk);
        assert (stall_seen > 0) else
            report_error("no schedule request ever stalled on a full instruction buffer");
        assert (!fetch_valid) else
            report_error("fetch output still valid after the last expected result");
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired with %0d of %0d fetches done", done_total, TOTAL);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

endmodule

// ==== flist.f ====
+incdir+test
hw/fetch_pkg.sv
hw/fetch_elastic_buf.sv
hw/fetch_pending_count.sv
hw/fetch_tag_store.sv
hw/fetch_decompress.sv
hw/fetch_unit.sv
test/tb_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the fetch stage testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_fetch -f flist.f -o tb_fetch; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_fetch 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
